// ==== design/tinyrv1_pkg.sv ====
package tinyrv1_pkg;

  //========================================================================
  // Opcodes
  //========================================================================

  localparam logic [6:0] op_add  = 7'b0110011;
  localparam logic [6:0] op_addi = 7'b0010011;
  localparam logic [6:0] op_bne  = 7'b1100011;
  localparam logic [6:0] op_jal  = 7'b1101111;

  // Function fields that make an R-type add
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [6:0] funct7_add = 7'b0000000;

  //========================================================================
  // Instruction fields
  //========================================================================

  localparam int opcode_lsb = 0;
  localparam int opcode_msb = 6;
  localparam int rd_lsb     = 7;
  localparam int rd_msb     = 11;
  localparam int funct3_lsb = 12;
  localparam int funct3_msb = 14;
  localparam int rs1_lsb    = 15;
  localparam int rs1_msb    = 19;
  localparam int rs2_lsb    = 20;
  localparam int rs2_msb    = 24;
  localparam int funct7_lsb = 25;
  localparam int funct7_msb = 31;

  //========================================================================
  // Select encodings
  //========================================================================

  typedef enum logic [1:0] {
    imm_i = 2'd0,
    imm_b = 2'd1,
    imm_j = 2'd2
  } imm_type_e;

  // Operand source, youngest producer first after the register file
  typedef enum logic [1:0] {
    byp_rf = 2'd0,
    byp_x  = 2'd1,
    byp_m  = 2'd2,
    byp_w  = 2'd3
  } byp_sel_e;

  typedef enum logic [1:0] {
    pc_plus4 = 2'd0,
    pc_jal   = 2'd1,
    pc_br    = 2'd2
  } pc_sel_e;

endpackage

// ==== design/regfile.sv ====
module regfile (
  input  logic        clk,

  // Write port
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,

  // Read ports
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired to zero whatever was written
  always_comb begin
    rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
    rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  end

endmodule

// ==== design/imm_gen.sv ====
module imm_gen (
  input  logic [31:0]            inst,
  input  tinyrv1_pkg::imm_type_e imm_type,
  output logic [31:0]            imm
);

  logic [31:0] imm_i_val;
  logic [31:0] imm_b_val;
  logic [31:0] imm_j_val;

  // I-type, addi
  assign imm_i_val = {{20{inst[31]}}, inst[31:20]};

  // B-type, bne offset in halfwords
  assign imm_b_val = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                      inst[11:8], 1'b0};

  // J-type, jal offset in halfwords
  assign imm_j_val = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                      inst[30:21], 1'b0};

  always_comb begin
    case (imm_type)
      tinyrv1_pkg::imm_i: imm = imm_i_val;
      tinyrv1_pkg::imm_b: imm = imm_b_val;
      tinyrv1_pkg::imm_j: imm = imm_j_val;
      default:            imm = 32'd0;
    endcase
  end

endmodule

// ==== design/proc_dpath.sv ====
module proc_dpath #(
  parameter logic [31:0] reset_pc = 32'h0000_0200
) (
  input  logic                   clk,
  input  logic                   arst_n,

  // Instruction memory
  output logic [31:0]            imemreq_addr,
  input  logic [31:0]            imemresp_data,

  // Control
  input  logic                   reg_en_f,
  input  logic                   reg_en_d,
  input  tinyrv1_pkg::pc_sel_e   pc_sel_f,
  input  tinyrv1_pkg::imm_type_e imm_type_d,
  input  tinyrv1_pkg::byp_sel_e  op1_byp_sel_d,
  input  tinyrv1_pkg::byp_sel_e  op2_byp_sel_d,
  input  logic                   op2_sel_d,
  input  logic                   result_sel_x,
  input  logic                   rf_wen_w,
  input  logic [4:0]             rf_waddr_w,

  // Status
  output logic [31:0]            inst_d,
  output logic                   eq_x,

  output logic [31:0]            trace_data
);

  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm_d;

  // Results fed back to the bypass muxes
  logic [31:0] result_x_next;
  logic [31:0] result_m;
  logic [31:0] result_w;

  //========================================================================
  // Stage F
  //========================================================================

  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] pc_d;
  logic [31:0] pc_x;
  logic [31:0] imm_x;

  always_comb begin
    case (pc_sel_f)
      tinyrv1_pkg::pc_jal: pc_next = pc_d + imm_d;
      tinyrv1_pkg::pc_br:  pc_next = pc_x + imm_x;
      default:             pc_next = pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else if (reg_en_f) begin
      pc <= pc_next;
    end
  end

  assign imemreq_addr = pc;

  // Loaded only when a fetch completes
  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      inst_d <= imemresp_data;
      pc_d   <= pc;
    end
  end

  //========================================================================
  // Stage D
  //========================================================================

  regfile u_regfile (
    .clk    (clk),
    .wen    (rf_wen_w),
    .waddr  (rf_waddr_w),
    .wdata  (result_w),
    .raddr0 (inst_d[tinyrv1_pkg::rs1_msb:tinyrv1_pkg::rs1_lsb]),
    .raddr1 (inst_d[tinyrv1_pkg::rs2_msb:tinyrv1_pkg::rs2_lsb]),
    .rdata0 (rs1_data),
    .rdata1 (rs2_data)
  );

  imm_gen u_imm_gen (
    .inst     (inst_d),
    .imm_type (imm_type_d),
    .imm      (imm_d)
  );

  logic [31:0] op1_byp;
  logic [31:0] op2_byp;

  always_comb begin
    case (op1_byp_sel_d)
      tinyrv1_pkg::byp_x: op1_byp = result_x_next;
      tinyrv1_pkg::byp_m: op1_byp = result_m;
      tinyrv1_pkg::byp_w: op1_byp = result_w;
      default:            op1_byp = rs1_data;
    endcase
    case (op2_byp_sel_d)
      tinyrv1_pkg::byp_x: op2_byp = result_x_next;
      tinyrv1_pkg::byp_m: op2_byp = result_m;
      tinyrv1_pkg::byp_w: op2_byp = result_w;
      default:            op2_byp = rs2_data;
    endcase
  end

  logic [31:0] op1_x;
  logic [31:0] op2_x;

  // Immediate kept apart from op2 so bne has both rs2 and its offset
  always_ff @(posedge clk) begin
    op1_x <= op1_byp;
    op2_x <= op2_sel_d ? imm_d : op2_byp;
    imm_x <= imm_d;
    pc_x  <= pc_d;
  end

  //========================================================================
  // Stage X
  //========================================================================

  assign eq_x = (op1_x == op2_x);

  // Sum for add/addi, link address for jal
  assign result_x_next = result_sel_x ? (pc_x + 32'd4) : (op1_x + op2_x);

  //========================================================================
  // Stages M and W
  //========================================================================

  always_ff @(posedge clk) begin
    result_m <= result_x_next;
    result_w <= result_m;
  end

  assign trace_data = result_w;

endmodule

// ==== design/proc_ctrl.sv ====
module proc_ctrl (
  input  logic                   clk,
  input  logic                   arst_n,

  // Instruction memory
  output logic                   imemreq_val,
  input  logic                   imemresp_val,

  // Status
  input  logic [31:0]            inst_d,
  input  logic                   eq_x,

  // Control
  output logic                   reg_en_f,
  output logic                   reg_en_d,
  output tinyrv1_pkg::pc_sel_e   pc_sel_f,
  output tinyrv1_pkg::imm_type_e imm_type_d,
  output tinyrv1_pkg::byp_sel_e  op1_byp_sel_d,
  output tinyrv1_pkg::byp_sel_e  op2_byp_sel_d,
  output logic                   op2_sel_d,
  output logic                   result_sel_x,
  output logic                   rf_wen_w,
  output logic [4:0]             rf_waddr_w,

  output logic                   trace_wen,
  output logic [4:0]             trace_waddr
);

  //========================================================================
  // Decode in D
  //========================================================================

  logic [6:0] opcode_d;
  logic [2:0] funct3_d;
  logic [6:0] funct7_d;
  logic [4:0] rd_d;
  logic [4:0] rs1_d;
  logic [4:0] rs2_d;

  assign opcode_d = inst_d[tinyrv1_pkg::opcode_msb:tinyrv1_pkg::opcode_lsb];
  assign funct3_d = inst_d[tinyrv1_pkg::funct3_msb:tinyrv1_pkg::funct3_lsb];
  assign funct7_d = inst_d[tinyrv1_pkg::funct7_msb:tinyrv1_pkg::funct7_lsb];
  assign rd_d     = inst_d[tinyrv1_pkg::rd_msb:tinyrv1_pkg::rd_lsb];
  assign rs1_d    = inst_d[tinyrv1_pkg::rs1_msb:tinyrv1_pkg::rs1_lsb];
  assign rs2_d    = inst_d[tinyrv1_pkg::rs2_msb:tinyrv1_pkg::rs2_lsb];

  logic is_add_d;
  logic is_addi_d;
  logic is_bne_d;
  logic is_jal_d;
  logic wen_d;

  assign is_add_d  = (opcode_d == tinyrv1_pkg::op_add) &&
                     (funct3_d == tinyrv1_pkg::funct3_add) &&
                     (funct7_d == tinyrv1_pkg::funct7_add);
  assign is_addi_d = (opcode_d == tinyrv1_pkg::op_addi);
  assign is_bne_d  = (opcode_d == tinyrv1_pkg::op_bne);
  assign is_jal_d  = (opcode_d == tinyrv1_pkg::op_jal);

  // x0 writes dropped here, so no bypass can ever match x0
  assign wen_d = (is_add_d || is_addi_d || is_jal_d) && (rd_d != 5'd0);

  always_comb begin
    imm_type_d = tinyrv1_pkg::imm_i;
    if (is_bne_d) begin
      imm_type_d = tinyrv1_pkg::imm_b;
    end else if (is_jal_d) begin
      imm_type_d = tinyrv1_pkg::imm_j;
    end
  end

  assign op2_sel_d = is_addi_d;

  //========================================================================
  // Stage state
  //========================================================================

  logic       run;
  logic       valid_d;
  logic       valid_x, wen_x, bne_x, jal_x;
  logic       valid_m, wen_m;
  logic       valid_w, wen_w;
  logic [4:0] rd_x, rd_m, rd_w;

  logic fetch_go;
  logic br_taken_x;
  logic jal_go_d;

  assign imemreq_val = run;
  assign fetch_go    = run && imemresp_val;
  assign br_taken_x  = valid_x && bne_x && !eq_x;
  // An older taken branch squashes the jal itself
  assign jal_go_d    = valid_d && is_jal_d && !br_taken_x;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run     <= 1'b0;
      valid_d <= 1'b0;
      valid_x <= 1'b0;
      wen_x   <= 1'b0;
      bne_x   <= 1'b0;
      jal_x   <= 1'b0;
      rd_x    <= 5'd0;
      valid_m <= 1'b0;
      wen_m   <= 1'b0;
      rd_m    <= 5'd0;
      valid_w <= 1'b0;
      wen_w   <= 1'b0;
      rd_w    <= 5'd0;
    end else begin
      run     <= 1'b1;
      // D empties when no fetch lands or F was squashed
      valid_d <= fetch_go && !br_taken_x && !jal_go_d;
      valid_x <= valid_d && !br_taken_x;
      wen_x   <= wen_d;
      bne_x   <= is_bne_d;
      jal_x   <= is_jal_d;
      rd_x    <= rd_d;
      valid_m <= valid_x;
      wen_m   <= wen_x;
      rd_m    <= rd_x;
      valid_w <= valid_m;
      wen_w   <= wen_m;
      rd_w    <= rd_m;
    end
  end

  //========================================================================
  // Fetch and redirect
  //========================================================================

  assign reg_en_f = fetch_go || br_taken_x || jal_go_d;
  assign reg_en_d = fetch_go;

  always_comb begin
    if (br_taken_x) begin
      pc_sel_f = tinyrv1_pkg::pc_br;
    end else if (jal_go_d) begin
      pc_sel_f = tinyrv1_pkg::pc_jal;
    end else begin
      pc_sel_f = tinyrv1_pkg::pc_plus4;
    end
  end

  //========================================================================
  // Bypass
  //========================================================================

  // Youngest older writer wins
  function automatic tinyrv1_pkg::byp_sel_e pick_byp(input logic [4:0] rs);
    if (valid_x && wen_x && (rd_x == rs)) begin
      return tinyrv1_pkg::byp_x;
    end else if (valid_m && wen_m && (rd_m == rs)) begin
      return tinyrv1_pkg::byp_m;
    end else if (valid_w && wen_w && (rd_w == rs)) begin
      return tinyrv1_pkg::byp_w;
    end
    return tinyrv1_pkg::byp_rf;
  endfunction

  always_comb begin
    op1_byp_sel_d = pick_byp(rs1_d);
    op2_byp_sel_d = pick_byp(rs2_d);
  end

  //========================================================================
  // Result and writeback
  //========================================================================

  assign result_sel_x = jal_x;
  assign rf_wen_w     = valid_w && wen_w;
  assign rf_waddr_w   = rd_w;
  assign trace_wen    = rf_wen_w;
  assign trace_waddr  = rd_w;

endmodule

// ==== design/proc.sv ====
module proc #(
  parameter logic [31:0] reset_pc = 32'h0000_0200
) (
  input  logic        clk,
  input  logic        arst_n,

  // Instruction memory
  output logic        imemreq_val,
  output logic [31:0] imemreq_addr,
  input  logic        imemresp_val,
  input  logic [31:0] imemresp_data,

  // Register write trace from W
  output logic        trace_wen,
  output logic [4:0]  trace_waddr,
  output logic [31:0] trace_data
);

  logic                   reg_en_f;
  logic                   reg_en_d;
  tinyrv1_pkg::pc_sel_e   pc_sel_f;
  tinyrv1_pkg::imm_type_e imm_type_d;
  tinyrv1_pkg::byp_sel_e  op1_byp_sel_d;
  tinyrv1_pkg::byp_sel_e  op2_byp_sel_d;
  logic                   op2_sel_d;
  logic                   result_sel_x;
  logic                   rf_wen_w;
  logic [4:0]             rf_waddr_w;
  logic [31:0]            inst_d;
  logic                   eq_x;

  proc_ctrl u_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .imemreq_val   (imemreq_val),
    .imemresp_val  (imemresp_val),
    .inst_d        (inst_d),
    .eq_x          (eq_x),
    .reg_en_f      (reg_en_f),
    .reg_en_d      (reg_en_d),
    .pc_sel_f      (pc_sel_f),
    .imm_type_d    (imm_type_d),
    .op1_byp_sel_d (op1_byp_sel_d),
    .op2_byp_sel_d (op2_byp_sel_d),
    .op2_sel_d     (op2_sel_d),
    .result_sel_x  (result_sel_x),
    .rf_wen_w      (rf_wen_w),
    .rf_waddr_w    (rf_waddr_w),
    .trace_wen     (trace_wen),
    .trace_waddr   (trace_waddr)
  );

  proc_dpath #(
    .reset_pc (reset_pc)
  ) u_dpath (
    .clk           (clk),
    .arst_n        (arst_n),
    .imemreq_addr  (imemreq_addr),
    .imemresp_data (imemresp_data),
    .reg_en_f      (reg_en_f),
    .reg_en_d      (reg_en_d),
    .pc_sel_f      (pc_sel_f),
    .imm_type_d    (imm_type_d),
    .op1_byp_sel_d (op1_byp_sel_d),
    .op2_byp_sel_d (op2_byp_sel_d),
    .op2_sel_d     (op2_sel_d),
    .result_sel_x  (result_sel_x),
    .rf_wen_w      (rf_wen_w),
    .rf_waddr_w    (rf_waddr_w),
    .inst_d        (inst_d),
    .eq_x          (eq_x),
    .trace_data    (trace_data)
  );

endmodule

// ==== test/clock_gen.sv ====
module clock_gen (
  output logic clk,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
  end

  always #4 clk = ~clk;

  // Hold reset for four rising edges, release just after the last one
  task automatic apply_reset();
    #1 arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;
  endtask

endmodule

// ==== test/proc_model.svh ====
// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] r;
  r = 32'd0;
  for (int k = 0; k < n; k++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = lfsr_step(lfsr_state);
  end
  return r;
endfunction

// Often one of the last three destinations
function automatic logic [4:0] pick_src(input logic [4:0] rec [3]);
  int sel;
  sel = int'(take_bits(2));
  if (sel != 0) begin
    return rec[sel % 3];
  end
  return 5'(take_bits(3));
endfunction

//==========================================================================
// Random program generator
//==========================================================================

task automatic build_program(input int n, input bit use_bne, input bit use_jal,
                             input bit x0_bias);
  logic [4:0]  rec [3];
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm;
  int          op;
  rec[0] = 5'd1;
  rec[1] = 5'd2;
  rec[2] = 5'd3;
  prog_len = n;
  for (int i = 0; i < n; i++) begin
    op = int'(take_bits(2));
    if (op == 2 && !use_bne) op = 0;
    if (op == 3 && !use_jal) op = 1;
    // Prologue sets x1..x7 from x0
    if (i < 7) op = 1;
    rd  = (x0_bias && take_bits(2) == 32'd0) ? 5'd0 : 5'(take_bits(3));
    rs1 = pick_src(rec);
    rs2 = pick_src(rec);
    if (i < 7) begin
      rd  = 5'(i + 1);
      rs1 = 5'd0;
    end
    if (op == 2 && take_bits(1) == 32'd1) rs2 = rs1;
    if (op == 1) begin
      imm = take_bits(12);
      imm = {{20{imm[11]}}, imm[11:0]};
    end else begin
      imm = (take_bits(2) + 32'd1) << 2;
    end
    case (op)
      0: prog_mem[i] = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
      1: prog_mem[i] = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      2: prog_mem[i] = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                        7'b1100011};
      default: prog_mem[i] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endcase
    p_op[i]  = op;
    p_rd[i]  = rd;
    p_rs1[i] = rs1;
    p_rs2[i] = rs2;
    p_imm[i] = imm;
    // In the x0 test a write to x0 also feeds later sources
    if (op != 2 && (rd != 5'd0 || x0_bias)) begin
      rec[2] = rec[1];
      rec[1] = rec[0];
      rec[0] = rd;
    end
  end
endtask

//==========================================================================
// Instruction-level reference model
//==========================================================================

task automatic run_model();
  logic [31:0] r [8];
  logic [31:0] v;
  int          i;
  int          steps;
  for (int k = 0; k < 8; k++) r[k] = 32'd0;
  exp_rd.delete();
  exp_val.delete();
  i = 0;
  steps = 0;
  while (i < prog_len && steps < 1000) begin
    steps++;
    v = 32'd0;
    case (p_op[i])
      0: v = r[p_rs1[i][2:0]] + r[p_rs2[i][2:0]];
      1: v = r[p_rs1[i][2:0]] + p_imm[i];
      3: v = reset_pc + 32'(i) * 32'd4 + 32'd4;
      default: v = 32'd0;
    endcase
    if (p_op[i] != 2 && p_rd[i] != 5'd0) begin
      r[p_rd[i][2:0]] = v;
      exp_rd.push_back(p_rd[i]);
      exp_val.push_back(v);
    end
    if (p_op[i] == 3 || (p_op[i] == 2 && r[p_rs1[i][2:0]] != r[p_rs2[i][2:0]])) begin
      i += int'(p_imm[i] >> 2);
    end else begin
      i++;
    end
  end
endtask

// ==== test/proc_tb.sv ====
module proc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] reset_pc = 32'h0000_0200;

  logic        clk;
  logic        arst_n;
  logic        imemreq_val;
  logic [31:0] imemreq_addr;
  logic        imemresp_val;
  logic [31:0] imemresp_data;
  logic        trace_wen;
  logic [4:0]  trace_waddr;
  logic [31:0] trace_data;

  logic [31:0] lfsr_state = 32'h6140;
  logic [31:0] prog_mem [256];
  int          prog_len = 0;
  int          p_op [256];
  logic [4:0]  p_rd [256];
  logic [4:0]  p_rs1 [256];
  logic [4:0]  p_rs2 [256];
  logic [31:0] p_imm [256];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];

  int wr_idx = 0;
  int test_errors = 0;
  int pass_count = 0;
  int fail_count = 0;
  bit checking = 0;
  bit stall_mode = 0;

  `include "proc_model.svh"

  clock_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  proc #(
    .reset_pc (reset_pc)
  ) u_proc (
    .clk           (clk),
    .arst_n        (arst_n),
    .imemreq_val   (imemreq_val),
    .imemreq_addr  (imemreq_addr),
    .imemresp_val  (imemresp_val),
    .imemresp_data (imemresp_data),
    .trace_wen     (trace_wen),
    .trace_waddr   (trace_waddr),
    .trace_data    (trace_data)
  );

  //========================================================================
  // Instruction memory
  //========================================================================

  // Past the program end a jal x0 to itself keeps the core spinning
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - reset_pc) >> 2;
    if (addr < reset_pc || idx >= 32'(prog_len)) return 32'h0000_006f;
    return prog_mem[idx[7:0]];
  endfunction

  initial begin
    imemresp_val  = 1'b0;
    imemresp_data = 32'd0;
  end

  always @(posedge clk) begin
    #1;
    imemresp_val  = stall_mode ? (take_bits(5) >= 32'd13) : 1'b1;
    imemresp_data = fetch_word(imemreq_addr);
  end

  //========================================================================
  // Commit and fetch checks
  //========================================================================

  logic [31:0] prev_addr = 32'd0;
  bit          prev_pending = 0;

  always @(negedge clk) begin
    if (!arst_n && (trace_wen || imemreq_val)) begin
      $display("FAIL %0t: output active during reset", $time);
      test_errors++;
    end
    if (checking && arst_n && trace_wen) begin
      if (wr_idx >= exp_rd.size()) begin
        $display("unexpected register write after program end at %0t", $time);
        test_errors++;
      end else begin
        if (trace_waddr != exp_rd[wr_idx] || trace_data != exp_val[wr_idx]) begin
          $display("FAIL %0t: expected x%0d = %h, got x%0d = %h", $time,
                   exp_rd[wr_idx], exp_val[wr_idx], trace_waddr, trace_data);
          test_errors++;
        end
        wr_idx++;
      end
    end
    if (checking && prev_pending && imemreq_addr != prev_addr) begin
      $display("FAIL %0t: fetch address moved from %h to %h while pending", $time,
               prev_addr, imemreq_addr);
      test_errors++;
    end
    // A redirect in this cycle may legally move a pending address
    prev_pending = imemreq_val && !imemresp_val &&
                   (u_proc.pc_sel_f == tinyrv1_pkg::pc_plus4);
    prev_addr = imemreq_addr;
  end

  //========================================================================
  // Tests
  //========================================================================

  task automatic run_test(input int num, input string name, input int n,
                          input bit use_bne, input bit use_jal, input bit x0_bias,
                          input bit stall);
    int cycles;
    checking   = 0;
    stall_mode = 0;
    test_errors = 0;
    build_program(n, use_bne, use_jal, x0_bias);
    run_model();
    wr_idx = 0;
    u_clk.apply_reset();
    @(negedge clk);
    if (imemreq_val || trace_wen) begin
      $display("FAIL %0t: request or write active in first cycle after reset", $time);
      test_errors++;
    end
    cycles = 0;
    while (!imemreq_val && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (!imemreq_val) begin
      $display("test %0d never issued a fetch after reset", num);
      test_errors++;
    end else if (imemreq_addr != reset_pc) begin
      $display("FAIL %0t: first fetch address %h, expected %h", $time,
               imemreq_addr, reset_pc);
      test_errors++;
    end
    checking   = 1;
    stall_mode = stall;
    cycles = 0;
    while (wr_idx < exp_rd.size() && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (wr_idx < exp_rd.size()) begin
      $display("test %0d timed out waiting for register writes", num);
      test_errors++;
    end else begin
      repeat (20) @(posedge clk);
    end
    checking = 0;
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d %s: ok, %0d writes", num, name, exp_rd.size());
    end else begin
      fail_count++;
      $display("test %0d %s: %0d errors", num, name, test_errors);
    end
  endtask

  initial begin
    run_test(1, "reset", 10, 0, 0, 0, 0);
    run_test(2, "arith_bypass", 60, 0, 0, 0, 0);
    run_test(3, "branches", 60, 1, 0, 0, 0);
    run_test(4, "jal", 60, 0, 1, 0, 0);
    run_test(5, "backpressure", 80, 1, 1, 0, 1);
    run_test(6, "x0", 60, 1, 1, 1, 0);
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+test
design/tinyrv1_pkg.sv
design/regfile.sv
design/imm_gen.sv
design/proc_dpath.sv
design/proc_ctrl.sv
design/proc.sv
test/clock_gen.sv
test/proc_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module proc_tb -o proc_sim

# Capture output even when the run itself reports failure
./obj_dir/proc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
